//--- include/prof_defines.svh
`ifndef PROF_DEFINES_SVH
`define PROF_DEFINES_SVH

// Trigger addresses in the instrumented wrapper

// First instruction of the wrapper around main
`define WRAP_MAIN_BEGIN 26'h0800100

// Return point after main finishes
`define WRAP_MAIN_END 26'h0800f00

// Memory layout of the profiler data

// Range table with two words per function (lo then hi)
`define RANGE_BASE 32'h0000_1000

// Count area with one word per function
`define COUNT_BASE 32'h0000_2000

`endif

//--- hdl/prof_pkg.sv
`default_nettype none

package prof_pkg;

	// Soft processor program counter
	localparam int PC_W = 26;

	// Memory side widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int BE_W = DATA_W / 8;

	// Inclusive address range of one function
	typedef struct packed {
		logic [PC_W-1:0] lo;
		logic [PC_W-1:0] hi;
	} range_t;

	// Everything the Avalon master drives
	typedef struct packed {
		logic read;
		logic write;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] writedata;
		logic [BE_W-1:0] byteenable;
	} avm_req_t;

	// Everything memory returns
	typedef struct packed {
		logic [DATA_W-1:0] readdata;
		logic waitrequest;
		logic readdatavalid;
	} avm_rsp_t;

endpackage

`default_nettype wire

//--- hdl/range_match.sv
`default_nettype none
`timescale 1ns/1ps

module range_match #(
	parameter int N_FUNCS = 8
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic enable,
	input logic [prof_pkg::PC_W-1:0] pc,
	input prof_pkg::range_t ranges [N_FUNCS],
	output logic hit,
	output logic [$clog2(N_FUNCS)-1:0] hit_index
);

	localparam int IW = $clog2(N_FUNCS);

	logic match;
	logic [IW-1:0] match_index;

	// All ranges compared in parallel
	// Walking downward leaves the lowest matching index
	always_comb begin
		match = 1'b0;
		match_index = '0;
		for (int i = N_FUNCS - 1; i >= 0; i--) begin
			if (pc >= ranges[i].lo && pc <= ranges[i].hi) begin
				match = 1'b1;
				match_index = IW'(i);
			end
		end
	end

	// Only unstalled cycles in the window count
	always_ff @(posedge clk) begin
		if (reset) begin
			hit <= 1'b0;
		end else begin
			hit <= match & enable & ~stall;
		end
	end

	always_ff @(posedge clk) begin
		hit_index <= match_index;
	end

endmodule

`default_nettype wire

//--- hdl/count_bank.sv
`default_nettype none
`timescale 1ns/1ps

module count_bank #(
	parameter int N_FUNCS = 8,
	parameter int CW = 32
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic inc,
	input logic [$clog2(N_FUNCS)-1:0] inc_index,
	input logic [$clog2(N_FUNCS)-1:0] rd_index,
	output logic [CW-1:0] rd_data
);

	// One cycle counter per profiled function
	logic [CW-1:0] counters [N_FUNCS];

	// Clear wins over a same-cycle increment
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			for (int i = 0; i < N_FUNCS; i++) begin
				counters[i] <= '0;
			end
		end else if (inc) begin
			// Wraps silently on overflow
			counters[inc_index] <= counters[inc_index] + 1'b1;
		end
	end

	// Read port feeds the write data of the master
	assign rd_data = counters[rd_index];

endmodule

`default_nettype wire

//--- hdl/prof_mem_master.sv
`default_nettype none
`timescale 1ns/1ps

module prof_mem_master #(
	parameter int N_FUNCS = 8,
	parameter int CW = 32,
	parameter logic [prof_pkg::ADDR_W-1:0] RANGE_BASE = '0,
	parameter logic [prof_pkg::ADDR_W-1:0] COUNT_BASE = '0
) (
	input logic clk,
	input logic reset,
	input logic load_go,
	input logic store_go,

	// Table words as they return
	output logic [prof_pkg::DATA_W-1:0] rd_word,
	output logic rd_valid,
	output logic [$clog2(2*N_FUNCS)-1:0] rd_index,

	// Counter being written
	output logic [$clog2(N_FUNCS)-1:0] wr_index,
	input logic [CW-1:0] wr_data,

	output logic load_done,
	output logic store_done,
	output prof_pkg::avm_req_t avm_req,
	input prof_pkg::avm_rsp_t avm_rsp
);

	localparam int RW = $clog2(2 * N_FUNCS);
	localparam int IW = $clog2(N_FUNCS);
	localparam int AW = prof_pkg::ADDR_W;
	localparam int DW = prof_pkg::DATA_W;
	localparam int N_WORDS = 2 * N_FUNCS;

	typedef enum logic [1:0] {M_IDLE, M_LOAD, M_STORE} mode_t;

	mode_t mode;
	logic [RW:0] issue_cnt;
	logic [RW:0] resp_cnt;
	logic accepted;
	logic last_resp;
	logic last_write;
	logic [AW-1:0] offset;

	// A command is taken when waitrequest is low
	assign accepted = (avm_req.read | avm_req.write) & ~avm_rsp.waitrequest;

	assign rd_valid = (mode == M_LOAD) & avm_rsp.readdatavalid;
	assign rd_word = avm_rsp.readdata;
	assign rd_index = resp_cnt[RW-1:0];
	assign wr_index = issue_cnt[IW-1:0];

	assign last_resp = rd_valid && (resp_cnt == (RW+1)'(N_WORDS - 1));
	assign last_write = avm_req.write && accepted && (issue_cnt == (RW+1)'(N_FUNCS - 1));

	// Word offset moves only on acceptance so the command holds still
	assign offset = AW'(issue_cnt) << 2;

	always_comb begin
		avm_req.read = (mode == M_LOAD) && (issue_cnt < (RW+1)'(N_WORDS));
		avm_req.write = (mode == M_STORE);
		avm_req.address = (mode == M_STORE) ? COUNT_BASE + offset : RANGE_BASE + offset;
		avm_req.writedata = DW'(wr_data);
		avm_req.byteenable = '1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= M_IDLE;
			issue_cnt <= '0;
			resp_cnt <= '0;
			load_done <= 1'b0;
			store_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			store_done <= 1'b0;
			case (mode)
				M_IDLE: begin
					issue_cnt <= '0;
					resp_cnt <= '0;
					if (load_go) begin
						mode <= M_LOAD;
					end else if (store_go) begin
						mode <= M_STORE;
					end
				end
				M_LOAD: begin
					// Issue and response sides run independently
					if (accepted) begin
						issue_cnt <= issue_cnt + 1'b1;
					end
					if (rd_valid) begin
						resp_cnt <= resp_cnt + 1'b1;
					end
					if (last_resp) begin
						mode <= M_IDLE;
						load_done <= 1'b1;
					end
				end
				M_STORE: begin
					if (accepted) begin
						issue_cnt <= issue_cnt + 1'b1;
					end
					if (last_write) begin
						mode <= M_IDLE;
						store_done <= 1'b1;
					end
				end
				default: mode <= M_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/snoop_prof.sv
`default_nettype none
`timescale 1ns/1ps

`include "prof_defines.svh"

module snoop_prof #(
	parameter int N_FUNCS = 8,
	parameter int CW = 32
) (
	input logic clk,
	input logic reset,
	input logic [prof_pkg::PC_W-1:0] pc,
	input logic stall,
	input logic init_start,
	output logic init_done,
	input logic retrieve_start,
	output logic retrieve_done,
	output prof_pkg::avm_req_t avm_req,
	input prof_pkg::avm_rsp_t avm_rsp
);

	localparam int RW = $clog2(2 * N_FUNCS);
	localparam int IW = $clog2(N_FUNCS);

	typedef enum logic [1:0] {P_IDLE, P_LOAD, P_COUNT, P_RETRIEVE} phase_t;

	phase_t phase;
	logic init_q;
	logic retrieve_q;
	logic start_load;
	logic start_store;
	logic count_en;
	prof_pkg::range_t ranges [N_FUNCS];
	logic [prof_pkg::DATA_W-1:0] rd_word;
	logic rd_valid;
	logic [RW-1:0] rd_index;
	logic [RW-2:0] load_slot;
	logic [IW-1:0] wr_index;
	logic [CW-1:0] count_value;
	logic hit;
	logic [IW-1:0] hit_index;

	// Rising edges of the requests from the trigger logic
	assign start_load = init_start & ~init_q & (phase == P_IDLE || phase == P_COUNT);
	assign start_store = retrieve_start & ~retrieve_q & (phase == P_COUNT);

	// Counting stops in the cycle retrieve is seen
	assign count_en = (phase == P_COUNT) & ~start_store;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= P_IDLE;
			init_q <= 1'b0;
			retrieve_q <= 1'b0;
		end else begin
			init_q <= init_start;
			retrieve_q <= retrieve_start;
			case (phase)
				P_IDLE, P_COUNT: begin
					if (start_load) begin
						phase <= P_LOAD;
					end else if (start_store) begin
						phase <= P_RETRIEVE;
					end
				end
				P_LOAD: begin
					if (init_done) begin
						phase <= P_COUNT;
					end
				end
				P_RETRIEVE: begin
					if (retrieve_done) begin
						phase <= P_IDLE;
					end
				end
				default: phase <= P_IDLE;
			endcase
		end
	end

	// Even words are lo bounds, odd words hi bounds
	assign load_slot = rd_index[RW-1:1];

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			if (rd_index[0]) begin
				ranges[load_slot].hi <= rd_word[prof_pkg::PC_W-1:0];
			end else begin
				ranges[load_slot].lo <= rd_word[prof_pkg::PC_W-1:0];
			end
		end
	end

	range_match #(
		.N_FUNCS(N_FUNCS)
	) matcher (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.enable(count_en),
		.pc(pc),
		.ranges(ranges),
		.hit(hit),
		.hit_index(hit_index)
	);

	count_bank #(
		.N_FUNCS(N_FUNCS),
		.CW(CW)
	) counters (
		.clk(clk),
		.reset(reset),
		.clear(start_load),
		.inc(hit),
		.inc_index(hit_index),
		.rd_index(wr_index),
		.rd_data(count_value)
	);

	prof_mem_master #(
		.N_FUNCS(N_FUNCS),
		.CW(CW),
		.RANGE_BASE(`RANGE_BASE),
		.COUNT_BASE(`COUNT_BASE)
	) master (
		.clk(clk),
		.reset(reset),
		.load_go(start_load),
		.store_go(start_store),
		.rd_word(rd_word),
		.rd_valid(rd_valid),
		.rd_index(rd_index),
		.wr_index(wr_index),
		.wr_data(count_value),
		.load_done(init_done),
		.store_done(retrieve_done),
		.avm_req(avm_req),
		.avm_rsp(avm_rsp)
	);

endmodule

`default_nettype wire

//--- hdl/prof_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "prof_defines.svh"

module prof_top #(
	parameter int N_FUNCS = 8,
	parameter int CW = 32
) (
	input logic clk,
	input logic reset,
	input logic [prof_pkg::PC_W-1:0] pc,
	input logic istall,
	input logic dstall,

	// Avalon profile master
	output prof_pkg::avm_req_t avm_req,
	input prof_pkg::avm_rsp_t avm_rsp
);

	logic stall;
	logic init_start;
	logic init_done;
	logic retrieve_start;
	logic retrieve_done;

	// Either pipeline stall freezes the PC
	assign stall = istall | dstall;

	// Trigger PCs set the requests, done pulses clear them
	always_ff @(posedge clk) begin
		if (reset) begin
			init_start <= 1'b0;
			retrieve_start <= 1'b0;
		end else begin
			if (pc == `WRAP_MAIN_BEGIN) begin
				init_start <= 1'b1;
			end else if (init_done) begin
				init_start <= 1'b0;
			end

			if (pc == `WRAP_MAIN_END) begin
				retrieve_start <= 1'b1;
			end else if (retrieve_done) begin
				retrieve_start <= 1'b0;
			end
		end
	end

	snoop_prof #(
		.N_FUNCS(N_FUNCS),
		.CW(CW)
	) snoop (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.stall(stall),
		.init_start(init_start),
		.init_done(init_done),
		.retrieve_start(retrieve_start),
		.retrieve_done(retrieve_done),
		.avm_req(avm_req),
		.avm_rsp(avm_rsp)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 5,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Released on a rising edge like the other synchronous inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/prof_assert.sv
`default_nettype none
`timescale 1ns/1ps

module prof_assert (
	input logic clk,
	input logic reset,
	input prof_pkg::avm_req_t avm_req,
	input prof_pkg::avm_rsp_t avm_rsp
);

	// One command at a time on the bus
	one_command: assert property (@(posedge clk) disable iff (reset)
		!(avm_req.read && avm_req.write))
		else $error("read and write high in the same cycle");

	// A stalled command stays put until memory takes it
	hold_on_wait: assert property (@(posedge clk) disable iff (reset)
		(avm_req.read || avm_req.write) && avm_rsp.waitrequest |=>
			$stable(avm_req.read) && $stable(avm_req.write) && $stable(avm_req.address)
			&& (!avm_req.write || $stable(avm_req.writedata)))
		else $error("command changed while waitrequest was high");

	full_byteenable: assert property (@(posedge clk) disable iff (reset)
		avm_req.write |-> avm_req.byteenable == 4'hf)
		else $error("byteenable %h on a write", avm_req.byteenable);

endmodule

bind prof_mem_master prof_assert check0 (
	.clk(clk),
	.reset(reset),
	.avm_req(avm_req),
	.avm_rsp(avm_rsp)
);

`default_nettype wire

//--- testbench/prof_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "prof_defines.svh"

module prof_tb;

	localparam int N_FUNCS = 8;
	localparam int CW = 32;
	localparam int PC_W = prof_pkg::PC_W;
	localparam int RESET_CYCLES = 8;
	// Worst session is about 250 cycles under heavy back-pressure
	localparam int RUN_CYCLES = 400;
	localparam int N_RUNS = 6;
	localparam int MAX_CYCLES = RESET_CYCLES + N_RUNS * RUN_CYCLES;
	localparam logic [PC_W-1:0] IDLE_PC = 26'h0000040;

	logic clk;
	logic reset;
	logic [PC_W-1:0] pc;
	logic istall;
	logic dstall;
	prof_pkg::avm_req_t avm_req;
	prof_pkg::avm_rsp_t avm_rsp = '0;

	// Memory model
	logic [31:0] mem [logic [31:0]];
	logic [31:0] lfsr = 32'd92582;
	logic heavy_wait = 1'b0;
	int cyc = 0;
	int last_due = 0;
	logic [31:0] pend_addr [$];
	int pend_due [$];
	logic [31:0] rd_addr_q [$];
	logic [31:0] wr_addr_q [$];
	logic [31:0] wr_data_q [$];
	logic [3:0] wr_be_q [$];

	// Range table and PC sequence of the current session
	prof_pkg::range_t tbl [N_FUNCS];
	logic [PC_W-1:0] seq_pc [$];
	logic seq_is [$];
	logic seq_ds [$];

	tb_clock #(
		.RESET_CYCLES(RESET_CYCLES)
	) clock0 (
		.clk(clk),
		.reset(reset)
	);

	prof_top #(
		.N_FUNCS(N_FUNCS),
		.CW(CW)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.istall(istall),
		.dstall(dstall),
		.avm_req(avm_req),
		.avm_rsp(avm_rsp)
	);

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic take_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	// Unwritten words return a pattern of the full address
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		return mem.exists(addr) ? mem[addr] : addr ^ 32'hc3a5_5a3c;
	endfunction

	always @(posedge clk) begin : mem_model
		logic b0;
		logic b1;
		int due;
		if (reset) begin
			avm_rsp <= '0;
			pend_addr.delete();
			pend_due.delete();
			last_due = 0;
		end else begin
			b0 = take_bit();
			b1 = take_bit();
			avm_rsp.waitrequest <= heavy_wait ? (b0 | b1) : (b0 & b1);
			avm_rsp.readdatavalid <= 1'b0;
			if (avm_req.read && !avm_rsp.waitrequest) begin
				b0 = take_bit();
				b1 = take_bit();
				// Latency of 1 to 3 cycles without overtaking an earlier read
				due = cyc + int'({b1, b0}) % 3;
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				pend_addr.push_back(avm_req.address);
				pend_due.push_back(due);
				rd_addr_q.push_back(avm_req.address);
			end
			if (avm_req.write && !avm_rsp.waitrequest) begin
				mem[avm_req.address] = avm_req.writedata;
				wr_addr_q.push_back(avm_req.address);
				wr_data_q.push_back(avm_req.writedata);
				wr_be_q.push_back(avm_req.byteenable);
			end
			if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
				avm_rsp.readdatavalid <= 1'b1;
				avm_rsp.readdata <= read_word(pend_addr.pop_front());
				void'(pend_due.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic int lowest_match(input logic [PC_W-1:0] p);
		for (int i = 0; i < N_FUNCS; i++) begin
			if (p >= tbl[i].lo && p <= tbl[i].hi) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic logic [PC_W-1:0] in_func(input int f, input int off);
		return tbl[f].lo + PC_W'(off);
	endfunction

	task automatic set_range(input int i, input logic [PC_W-1:0] lo, input logic [PC_W-1:0] hi);
		tbl[i].lo = lo;
		tbl[i].hi = hi;
	endtask

	task automatic disjoint_table();
		for (int i = 0; i < N_FUNCS; i++) begin
			set_range(i, PC_W'(32'h10000 + 32'h200 * i), PC_W'(32'h100ff + 32'h200 * i));
		end
	endtask

	task automatic add_cycles(input logic [PC_W-1:0] p, input int n, input logic i_st,
			input logic d_st);
		repeat (n) begin
			seq_pc.push_back(p);
			seq_is.push_back(i_st);
			seq_ds.push_back(d_st);
		end
	endtask

	// One session from the begin trigger to the written counters
	task automatic run_profile();
		int exp_cnt [N_FUNCS];
		int idx;
		for (int i = 0; i < N_FUNCS; i++) begin
			exp_cnt[i] = 0;
			// Upper bits lie outside the PC
			mem[`RANGE_BASE + 32'(8 * i)] = {6'h2a, tbl[i].lo};
			mem[`RANGE_BASE + 32'(8 * i + 4)] = {6'h15, tbl[i].hi};
		end
		rd_addr_q.delete();
		wr_addr_q.delete();
		wr_data_q.delete();
		wr_be_q.delete();

		@(posedge clk);
		pc <= `WRAP_MAIN_BEGIN;
		@(posedge clk);
		pc <= IDLE_PC;
		do @(posedge clk); while (!dut0.init_done);
		check_eq("number of table reads", 32'(rd_addr_q.size()), 32'(2 * N_FUNCS));
		for (int i = 0; i < 2 * N_FUNCS; i++) begin
			check_eq($sformatf("avm_req.address of read %0d", i), rd_addr_q[i],
				`RANGE_BASE + 32'(4 * i));
		end

		repeat (2) @(posedge clk);
		foreach (seq_pc[c]) begin
			pc <= seq_pc[c];
			istall <= seq_is[c];
			dstall <= seq_ds[c];
			idx = lowest_match(seq_pc[c]);
			if (idx >= 0 && !seq_is[c] && !seq_ds[c]) begin
				exp_cnt[idx]++;
			end
			@(posedge clk);
		end
		pc <= IDLE_PC;
		istall <= 1'b0;
		dstall <= 1'b0;
		repeat (3) @(posedge clk);
		pc <= `WRAP_MAIN_END;
		@(posedge clk);
		pc <= IDLE_PC;
		do @(posedge clk); while (!dut0.retrieve_done);

		check_eq("number of counter writes", 32'(wr_addr_q.size()), 32'(N_FUNCS));
		for (int i = 0; i < N_FUNCS; i++) begin
			check_eq($sformatf("avm_req.address of write %0d", i), wr_addr_q[i],
				`COUNT_BASE + 32'(4 * i));
			check_eq($sformatf("avm_req.writedata[%0d]", i), wr_data_q[i], 32'(exp_cnt[i]));
			check_eq($sformatf("avm_req.byteenable[%0d]", i), 32'(wr_be_q[i]), 32'hf);
		end
		seq_pc.delete();
		seq_is.delete();
		seq_ds.delete();
	endtask

	task automatic init_and_count();
		disjoint_table();
		add_cycles(in_func(0, 4), 5, 1'b0, 1'b0);
		add_cycles(in_func(3, 32), 7, 1'b0, 1'b0);
		add_cycles(in_func(5, 0), 3, 1'b0, 1'b0);
		add_cycles(IDLE_PC, 4, 1'b0, 1'b0);
		add_cycles(tbl[7].hi, 1, 1'b0, 1'b0);
		add_cycles(in_func(0, 0), 2, 1'b0, 1'b0);
		run_profile();
	endtask

	task automatic stall_cycles();
		disjoint_table();
		add_cycles(in_func(1, 8), 4, 1'b0, 1'b0);
		add_cycles(in_func(1, 9), 3, 1'b1, 1'b0);
		add_cycles(in_func(2, 16), 5, 1'b0, 1'b1);
		add_cycles(in_func(2, 17), 2, 1'b1, 1'b1);
		add_cycles(in_func(2, 18), 6, 1'b0, 1'b0);
		add_cycles(in_func(6, 1), 3, 1'b1, 1'b0);
		run_profile();
	endtask

	// Ranges 0 and 1 overlap, range 2 covers both
	task automatic overlap_priority();
		set_range(0, 26'h0020000, 26'h00200ff);
		set_range(1, 26'h0020080, 26'h00201ff);
		set_range(2, 26'h0020000, 26'h0020fff);
		for (int i = 3; i < N_FUNCS; i++) begin
			set_range(i, PC_W'(32'h30000 + 32'h200 * i), PC_W'(32'h300ff + 32'h200 * i));
		end
		add_cycles(26'h0020010, 4, 1'b0, 1'b0);
		add_cycles(26'h0020090, 3, 1'b0, 1'b0);
		add_cycles(26'h0020150, 5, 1'b0, 1'b0);
		add_cycles(26'h0020800, 2, 1'b0, 1'b0);
		add_cycles(26'h002f000, 4, 1'b0, 1'b0);
		add_cycles(26'h00201ff, 1, 1'b0, 1'b0);
		add_cycles(26'h0020100, 2, 1'b0, 1'b0);
		run_profile();
	endtask

	task automatic retrieve_backpressure();
		heavy_wait <= 1'b1;
		disjoint_table();
		for (int i = 0; i < N_FUNCS; i++) begin
			add_cycles(in_func(i, 3 * i), i + 2, 1'b0, 1'b0);
		end
		run_profile();
		heavy_wait <= 1'b0;
	endtask

	// Second session must not carry the first one's cycles
	task automatic rerun_clears();
		disjoint_table();
		add_cycles(in_func(4, 2), 9, 1'b0, 1'b0);
		add_cycles(in_func(2, 5), 3, 1'b0, 1'b0);
		run_profile();
		add_cycles(in_func(4, 7), 2, 1'b0, 1'b0);
		add_cycles(in_func(6, 3), 5, 1'b0, 1'b0);
		run_profile();
	endtask

	initial begin
		pc = IDLE_PC;
		istall = 1'b0;
		dstall = 1'b0;
		@(posedge clk);
		while (reset) @(posedge clk);
		check_eq("avm_req.read", 32'(avm_req.read), 32'h0);
		check_eq("avm_req.write", 32'(avm_req.write), 32'h0);
		check_eq("init_start", 32'(dut0.init_start), 32'h0);
		check_eq("retrieve_start", 32'(dut0.retrieve_start), 32'h0);
		init_and_count();
		stall_cycles();
		overlap_priority();
		retrieve_backpressure();
		rerun_clears();
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
hdl/prof_pkg.sv
hdl/range_match.sv
hdl/count_bank.sv
hdl/prof_mem_master.sv
hdl/snoop_prof.sv
hdl/prof_top.sv
testbench/tb_clock.sv
testbench/prof_assert.sv
testbench/prof_tb.sv

//--- Makefile
TOP = prof_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
